// ==== bench/bus_patterns.hex ====
// Columns: master rw address wdata expected_rdata (master 0 is A, rw 1 is a write)
// expected_rdata is used for LED reads and faults, RAM reads use the testbench model
0 1 10000010 a5a50001 00000000
0 0 10000010 00000000 00000000
0 1 40000000 000003c5 00000000
0 0 40000000 00000000 000003c5
0 1 20000010 deadbeef 00000000
0 0 10000010 00000000 00000000
0 0 f0000000 00000000 00000000
0 1 10000820 11110000 00000000
0 0 10000020 00000000 00000000
0 1 4000ffff 12345678 00000000
0 0 40000000 00000000 00000278
1 1 10000400 b0000001 00000000
1 1 10000404 b0000002 00000000
1 1 10000408 b0000003 00000000
1 0 10000400 00000000 00000000
1 0 10000404 00000000 00000000
1 0 10000408 00000000 00000000
1 0 50000000 00000000 00000000

// ==== bench/tb_soc_bus.sv ====
`include "soc_bus_cfg.svh"

module tb_soc_bus import soc_bus_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_PAT      = 18;
	localparam int FIELDS       = 5;
	localparam int RESET_CYCLES = 10;
	localparam int CYCLE_LIMIT  = NUM_PAT * (`QUEUE_DEPTH + `RAM_LATENCY + 8) + 100;
	localparam int IDX_W        = $clog2(`RAM_WORDS);
	localparam logic [15:0] LFSR_SEED = 16'd63818;
	localparam logic [15:0] LFSR_TAPS = 16'hb400;

	// Columns of a pattern line
	localparam int COL_MASTER = 0;
	localparam int COL_RW     = 1;
	localparam int COL_ADDR   = 2;
	localparam int COL_WDATA  = 3;
	localparam int COL_EXP    = 4;

	logic       i_clk;
	logic       i_rst_n;
	logic       i_a_valid;
	logic       i_a_rw;
	bus_addr_t  i_a_address;
	bus_data_t  i_a_wdata;
	logic       o_a_ready;
	logic       i_b_valid;
	logic       i_b_rw;
	bus_addr_t  i_b_address;
	bus_data_t  i_b_wdata;
	logic       o_b_ready;
	logic       o_rsp_valid;
	master_id_t o_rsp_master;
	bus_data_t  o_rsp_rdata;
	logic       o_rsp_fault;
	led_t       o_led;

	logic [31:0] pattern [NUM_PAT*FIELDS];
	int          cur_idx [2];
	int          gap_len [NUM_PAT];
	logic [15:0] lfsr_state;

	// Reference model of the slaves
	bus_data_t   model_ram     [`RAM_WORDS];
	logic        model_written [`RAM_WORDS];
	led_t        model_led;

	// Expected responses in acceptance order
	master_id_t  exp_master [$];
	bus_data_t   exp_rdata  [$];
	logic        exp_fault  [$];
	led_t        exp_led    [$];

	int          cycle_count       = 0;
	int          checked_count     = 0;
	int          stall_cycles      = 0;
	int          both_valid_cycles = 0;

	soc_bus_top dut (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_a_valid    (i_a_valid),
		.i_a_rw       (i_a_rw),
		.i_a_address  (i_a_address),
		.i_a_wdata    (i_a_wdata),
		.o_a_ready    (o_a_ready),
		.i_b_valid    (i_b_valid),
		.i_b_rw       (i_b_rw),
		.i_b_address  (i_b_address),
		.i_b_wdata    (i_b_wdata),
		.o_b_ready    (o_b_ready),
		.o_rsp_valid  (o_rsp_valid),
		.o_rsp_master (o_rsp_master),
		.o_rsp_rdata  (o_rsp_rdata),
		.o_rsp_fault  (o_rsp_fault),
		.o_led        (o_led)
	);

	always #5 i_clk = ~i_clk;

	// ====================================================================
	// Failure reporting and checks
	// ====================================================================

	task automatic abort_run();
		$display("Some tests failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic report_failure(input string reason);
		$display("Error at %0t: %s", $time, reason);
		abort_run();
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
			abort_run();
		end
	endtask

	// ====================================================================
	// Stimulus
	// ====================================================================

	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
	endfunction

	// One LFSR step per bit
	task automatic random_bits(input int n, output int value);
		int i;

		value = 0;
		for (i = 0; i < n; i++) begin
			value = (value << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic logic [31:0] field(input int idx, input int col);
		return pattern[idx*FIELDS + col];
	endfunction

	task automatic put_request(input int m, input logic valid, input logic rw,
		input bus_addr_t addr, input bus_data_t wdata);
		if (m == 0) begin
			i_a_valid   <= valid;
			i_a_rw      <= rw;
			i_a_address <= addr;
			i_a_wdata   <= wdata;
		end else begin
			i_b_valid   <= valid;
			i_b_rw      <= rw;
			i_b_address <= addr;
			i_b_wdata   <= wdata;
		end
	endtask

	// Issues this master's lines in file order, holding each until accepted
	task automatic run_master(input int m);
		int          idx;
		logic [31:0] rw_word;

		@(posedge i_clk);
		for (idx = 0; idx < NUM_PAT; idx++) begin
			if (field(idx, COL_MASTER) == m) begin
				if (gap_len[idx] > 0) begin
					put_request(m, 1'b0, 1'b0, '0, '0);
					repeat (gap_len[idx]) @(posedge i_clk);
				end
				cur_idx[m] = idx;
				rw_word = field(idx, COL_RW);
				put_request(m, 1'b1, rw_word[0], field(idx, COL_ADDR), field(idx, COL_WDATA));
				do begin
					@(negedge i_clk);
				end while (!((m == 0) ? o_a_ready : o_b_ready));
				@(posedge i_clk);
			end
		end
		put_request(m, 1'b0, 1'b0, '0, '0);
	endtask

	// ====================================================================
	// Expected-response model
	// ====================================================================

	task automatic record_request(input int m);
		logic             rw;
		bus_addr_t        addr;
		bus_data_t        wdata;
		bus_data_t        rdata;
		logic             fault;
		logic [3:0]       region;
		logic [IDX_W-1:0] word;

		rw     = (m == 0) ? i_a_rw : i_b_rw;
		addr   = (m == 0) ? i_a_address : i_b_address;
		wdata  = (m == 0) ? i_a_wdata : i_b_wdata;
		region = addr[`BUS_ADDR_W-1 -: 4];
		word   = IDX_W'((addr >> 2) % `RAM_WORDS);
		rdata  = '0;
		fault  = 1'b0;
		if (region == 4'(`REGION_RAM)) begin
			if (rw) begin
				model_ram[word]     = wdata;
				model_written[word] = 1'b1;
			end else if (!model_written[word]) begin
				report_failure("pattern file reads a RAM word that was never written");
			end else begin
				rdata = model_ram[word];
			end
		end else if (region == 4'(`REGION_LED)) begin
			if (rw) begin
				model_led = wdata[`LED_W-1:0];
			end else begin
				rdata = field(cur_idx[m], COL_EXP);
			end
		end else begin
			fault = 1'b1;
			rdata = field(cur_idx[m], COL_EXP);
		end
		exp_master.push_back(master_id_t'(m));
		exp_rdata.push_back(rdata);
		exp_fault.push_back(fault);
		exp_led.push_back(model_led);
	endtask

	task automatic check_response();
		if (exp_master.size() == 0) begin
			report_failure("a response arrived with no request outstanding");
		end else begin
			check_value("o_rsp_master", 32'(o_rsp_master), 32'(exp_master.pop_front()));
			check_value("o_rsp_rdata", o_rsp_rdata, exp_rdata.pop_front());
			check_value("o_rsp_fault", 32'(o_rsp_fault), 32'(exp_fault.pop_front()));
			check_value("o_led", 32'(o_led), 32'(exp_led.pop_front()));
			checked_count++;
		end
	endtask

	// Handshakes and responses are sampled mid-cycle
	always @(negedge i_clk) begin
		if (i_rst_n) begin
			if (o_rsp_valid) begin
				check_response();
			end
			if (i_a_valid && i_b_valid) begin
				both_valid_cycles++;
			end
			if (i_a_valid && i_b_valid && o_b_ready) begin
				report_failure("master B was accepted while master A was also requesting");
			end
			if ((i_a_valid && !o_a_ready) || (i_b_valid && !i_a_valid && !o_b_ready)) begin
				stall_cycles++;
			end
			if (i_a_valid && o_a_ready) begin
				record_request(0);
			end else if (i_b_valid && o_b_ready) begin
				record_request(1);
			end
		end
	end

	always @(posedge i_clk) begin
		if (i_rst_n) begin
			cycle_count++;
			if (cycle_count >= CYCLE_LIMIT) begin
				report_failure("timeout, not all responses arrived in time");
			end
		end
	end

	// ====================================================================
	// Main sequence
	// ====================================================================

	initial begin
		int i;
		int waited;
		int gap;

		i_clk       = 1'b0;
		i_rst_n     = 1'b0;
		i_a_valid   = 1'b0;
		i_a_rw      = 1'b0;
		i_a_address = '0;
		i_a_wdata   = '0;
		i_b_valid   = 1'b0;
		i_b_rw      = 1'b0;
		i_b_address = '0;
		i_b_wdata   = '0;
		lfsr_state  = LFSR_SEED;
		model_led   = '0;
		cur_idx[0]  = 0;
		cur_idx[1]  = 0;
		for (i = 0; i < `RAM_WORDS; i++) begin
			model_written[i] = 1'b0;
		end

		// Marker values expose a short file
		for (i = 0; i < NUM_PAT*FIELDS; i++) begin
			pattern[i] = 32'hdead0000 | 32'(i);
		end
		$readmemh("bench/bus_patterns.hex", pattern);
		for (i = 0; i < NUM_PAT; i++) begin
			if (field(i, COL_MASTER) > 1 || field(i, COL_RW) > 1) begin
				report_failure("pattern file bench/bus_patterns.hex is missing or malformed");
			end
		end

		// Idle gap before each line, drawn in file order
		for (i = 0; i < NUM_PAT; i++) begin
			random_bits(2, gap);
			gap_len[i] = gap;
		end

		repeat (RESET_CYCLES - 1) @(posedge i_clk);
		@(negedge i_clk);
		check_value("o_a_ready in reset", 32'(o_a_ready), 32'd0);
		check_value("o_b_ready in reset", 32'(o_b_ready), 32'd0);
		check_value("o_rsp_valid in reset", 32'(o_rsp_valid), 32'd0);
		check_value("o_led in reset", 32'(o_led), 32'd0);
		@(posedge i_clk);
		i_rst_n <= 1'b1;

		waited = 0;
		@(negedge i_clk);
		while (!(o_a_ready && o_b_ready)) begin
			waited++;
			if (waited > 4) begin
				report_failure("ready outputs did not rise after reset");
			end
			@(negedge i_clk);
		end

		fork
			run_master(0);
			run_master(1);
		join

		while (checked_count < NUM_PAT) begin
			@(negedge i_clk);
		end
		// Any extra response shows up here
		repeat (2 * `RAM_LATENCY) @(negedge i_clk);

		if (stall_cycles == 0) begin
			report_failure("the request queue never filled, so no back-pressure was seen");
		end else if (both_valid_cycles == 0) begin
			report_failure("masters A and B never requested in the same cycle");
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the bus testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log
TOP=tb_soc_bus

verilator --binary --timing --timescale 1ns/1ps -j 0 \
	--top-module "$TOP" --Mdir "$OBJ_DIR" -f soc_bus.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation ended with status $run_status"
	exit 1
fi

if grep -q "All tests passed" "$LOG"; then
	echo "Result: PASS"
	exit 0
fi
echo "Result: FAIL"
exit 1

// ==== soc_bus.f ====
+incdir+verilog
verilog/soc_bus_pkg.sv
verilog/bus_req_if.sv
verilog/bus_arbiter.sv
verilog/request_queue.sv
verilog/slave_decoder.sv
verilog/soc_bus_top.sv
bench/tb_soc_bus.sv

// ==== verilog/bus_arbiter.sv ====
module bus_arbiter import soc_bus_pkg::*; (
	input  logic        i_clk,
	input  logic        i_rst_n,

	// Master A, processor data port
	input  logic        i_a_valid,
	input  logic        i_a_rw,
	input  bus_addr_t   i_a_address,
	input  bus_data_t   i_a_wdata,
	output logic        o_a_ready,

	// Master B, DMA port
	input  logic        i_b_valid,
	input  logic        i_b_rw,
	input  bus_addr_t   i_b_address,
	input  bus_data_t   i_b_wdata,
	output logic        o_b_ready,

	bus_req_if.producer out
);

	logic grant_en;
	logic load;
	logic take_a;
	logic take_b;

	// ====================================================================
	// Grant logic
	// ====================================================================

	// Output register is empty or drains this cycle
	assign load = !out.valid || out.ready;

	assign o_a_ready = grant_en && load;
	// B only gets the slot when A is not asking
	assign o_b_ready = grant_en && load && !i_a_valid;

	assign take_a = i_a_valid && o_a_ready;
	assign take_b = i_b_valid && o_b_ready;

	// ====================================================================
	// Output register
	// ====================================================================

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			grant_en  <= 1'b0;
			out.valid <= 1'b0;
		end else begin
			// Grants open one cycle after reset release
			grant_en <= 1'b1;
			if (load) begin
				out.valid <= take_a || take_b;
			end
		end
	end

	// Request payload, held while downstream stalls
	always_ff @(posedge i_clk) begin
		if (take_a) begin
			out.rw      <= i_a_rw;
			out.master  <= master_id_t'(1'b0);
			out.address <= i_a_address;
			out.wdata   <= i_a_wdata;
		end else if (take_b) begin
			out.rw      <= i_b_rw;
			out.master  <= master_id_t'(1'b1);
			out.address <= i_b_address;
			out.wdata   <= i_b_wdata;
		end
	end

endmodule

// ==== verilog/bus_req_if.sv ====
// One request channel, valid/ready handshake
interface bus_req_if import soc_bus_pkg::*; ();

	logic       valid;
	logic       ready;
	// High for a write
	logic       rw;
	master_id_t master;
	bus_addr_t  address;
	bus_data_t  wdata;

	modport producer (
		output valid,
		output rw,
		output master,
		output address,
		output wdata,
		input  ready
	);

	modport consumer (
		input  valid,
		input  rw,
		input  master,
		input  address,
		input  wdata,
		output ready
	);

endinterface

// ==== verilog/request_queue.sv ====
module request_queue import soc_bus_pkg::*; #(
	parameter int DEPTH = 4
) (
	input  logic        i_clk,
	input  logic        i_rst_n,
	bus_req_if.consumer in,
	bus_req_if.producer out
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
	localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

	// Entry storage, one array per field
	logic             rw_mem     [DEPTH];
	master_id_t       master_mem [DEPTH];
	bus_addr_t        addr_mem   [DEPTH];
	bus_data_t        data_mem   [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	// Circular increment, also for depths that are not a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == LAST_PTR) ? '0 : ptr + PTR_W'(1);
	endfunction

	assign in.ready  = (count != FULL_CNT);
	assign out.valid = (count != '0);
	assign push      = in.valid && in.ready;
	assign pop       = out.valid && out.ready;

	// Head entry
	assign out.rw      = rw_mem[rd_ptr];
	assign out.master  = master_mem[rd_ptr];
	assign out.address = addr_mem[rd_ptr];
	assign out.wdata   = data_mem[rd_ptr];

	always_ff @(posedge i_clk) begin
		if (push) begin
			rw_mem[wr_ptr]     <= in.rw;
			master_mem[wr_ptr] <= in.master;
			addr_mem[wr_ptr]   <= in.address;
			data_mem[wr_ptr]   <= in.wdata;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({push, pop})
				2'b10:   count <= count + CNT_W'(1);
				2'b01:   count <= count - CNT_W'(1);
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== verilog/slave_decoder.sv ====
`include "soc_bus_cfg.svh"

module slave_decoder import soc_bus_pkg::*; (
	input  logic        i_clk,
	input  logic        i_rst_n,
	bus_req_if.consumer req,

	// Response channel, one pulse per request
	output logic        o_rsp_valid,
	output master_id_t  o_rsp_master,
	output bus_data_t   o_rsp_rdata,
	output logic        o_rsp_fault,

	output led_t        o_led
);

	localparam int RAM_IDX_W = $clog2(`RAM_WORDS);
	localparam int WAIT_W    = $clog2(`RAM_LATENCY);
	// Acceptance cycle and the RESPOND cycle are not counted
	localparam logic [WAIT_W-1:0] WAIT_LOAD = WAIT_W'(`RAM_LATENCY - 2);

	slave_state_e         state;
	logic [WAIT_W-1:0]    wait_cnt;
	logic [3:0]           region;
	logic                 accept;
	logic                 sel_ram;
	logic                 sel_led;
	logic [RAM_IDX_W-1:0] ram_idx;

	bus_data_t            ram [`RAM_WORDS];
	bus_data_t            ram_rdata;
	led_t                 led_q;

	// Response payload captured at acceptance
	master_id_t           master_q;
	bus_data_t            rdata_q;
	logic                 fault_q;
	logic                 from_ram_q;

	// ====================================================================
	// Address decode
	// ====================================================================

	assign region  = req.address[`BUS_ADDR_W-1 -: 4];
	assign sel_ram = (region == 4'(`REGION_RAM));
	assign sel_led = (region == 4'(`REGION_LED));
	// Word index, higher bits alias
	assign ram_idx = req.address[RAM_IDX_W+1:2];

	assign req.ready = (state == IDLE);
	assign accept    = req.valid && req.ready;

	// ====================================================================
	// Sequencing
	// ====================================================================

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state    <= IDLE;
			wait_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (accept && sel_ram) begin
						state    <= RAM_WAIT;
						wait_cnt <= WAIT_LOAD;
					end else if (accept) begin
						state <= RESPOND;
					end
				end
				RAM_WAIT: begin
					if (wait_cnt == '0) begin
						state <= RESPOND;
					end else begin
						wait_cnt <= wait_cnt - WAIT_W'(1);
					end
				end
				RESPOND: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// ====================================================================
	// Slaves
	// ====================================================================

	// RAM, read-before-write on the same access
	always_ff @(posedge i_clk) begin
		if (accept && sel_ram) begin
			if (req.rw) begin
				ram[ram_idx] <= req.wdata;
			end
			ram_rdata <= ram[ram_idx];
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			led_q <= '0;
		end else if (accept && sel_led && req.rw) begin
			led_q <= req.wdata[`LED_W-1:0];
		end
	end

	// Unmapped regions fault with zero data
	always_ff @(posedge i_clk) begin
		if (accept) begin
			master_q   <= req.master;
			fault_q    <= !(sel_ram || sel_led);
			from_ram_q <= sel_ram && !req.rw;
			rdata_q    <= (sel_led && !req.rw) ? bus_data_t'(led_q) : '0;
		end
	end

	assign o_rsp_valid  = (state == RESPOND);
	assign o_rsp_master = master_q;
	assign o_rsp_fault  = fault_q;
	assign o_rsp_rdata  = from_ram_q ? ram_rdata : rdata_q;
	assign o_led        = led_q;

endmodule

// ==== verilog/soc_bus_cfg.svh ====
`ifndef SOC_BUS_CFG_SVH
`define SOC_BUS_CFG_SVH

// ====================================================================
// Bus geometry
// ====================================================================
`define BUS_ADDR_W 32
`define BUS_DATA_W 32

// Request queue entries between arbiter and slaves
`define QUEUE_DEPTH 4

// ====================================================================
// Slaves
// ====================================================================
// Word-addressed on-chip RAM
`define RAM_WORDS 512
// Cycles from acceptance to response, must be 2 or more
`define RAM_LATENCY 4

// Top address nibble of each region
`define REGION_RAM 1
`define REGION_LED 4

`define LED_W 10

`endif

// ==== verilog/soc_bus_pkg.sv ====
`include "soc_bus_cfg.svh"

package soc_bus_pkg;

	// Address and data as seen on every request channel
	typedef logic [`BUS_ADDR_W-1:0] bus_addr_t;
	typedef logic [`BUS_DATA_W-1:0] bus_data_t;

	// Request origin, 0 for master A (processor) and 1 for master B (DMA)
	typedef logic [0:0] master_id_t;

	// Board LED bank
	typedef logic [`LED_W-1:0] led_t;

	// Slave stage sequencing
	typedef enum logic [1:0] {
		IDLE,
		RAM_WAIT,
		RESPOND
	} slave_state_e;

endpackage

// ==== verilog/soc_bus_top.sv ====
`include "soc_bus_cfg.svh"

module soc_bus_top import soc_bus_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst_n,

	// Master A
	input  logic       i_a_valid,
	input  logic       i_a_rw,
	input  bus_addr_t  i_a_address,
	input  bus_data_t  i_a_wdata,
	output logic       o_a_ready,

	// Master B
	input  logic       i_b_valid,
	input  logic       i_b_rw,
	input  bus_addr_t  i_b_address,
	input  bus_data_t  i_b_wdata,
	output logic       o_b_ready,

	// Responses
	output logic       o_rsp_valid,
	output master_id_t o_rsp_master,
	output bus_data_t  o_rsp_rdata,
	output logic       o_rsp_fault,

	output led_t       o_led
);

	bus_req_if arb_to_queue ();
	bus_req_if queue_to_slave ();

	bus_arbiter u_arbiter (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_a_valid   (i_a_valid),
		.i_a_rw      (i_a_rw),
		.i_a_address (i_a_address),
		.i_a_wdata   (i_a_wdata),
		.o_a_ready   (o_a_ready),
		.i_b_valid   (i_b_valid),
		.i_b_rw      (i_b_rw),
		.i_b_address (i_b_address),
		.i_b_wdata   (i_b_wdata),
		.o_b_ready   (o_b_ready),
		.out         (arb_to_queue.producer)
	);

	// Lets requests pile up while the RAM is busy
	request_queue #(
		.DEPTH (`QUEUE_DEPTH)
	) u_queue (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.in      (arb_to_queue.consumer),
		.out     (queue_to_slave.producer)
	);

	slave_decoder u_slaves (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.req          (queue_to_slave.consumer),
		.o_rsp_valid  (o_rsp_valid),
		.o_rsp_master (o_rsp_master),
		.o_rsp_rdata  (o_rsp_rdata),
		.o_rsp_fault  (o_rsp_fault),
		.o_led        (o_led)
	);

endmodule
